/* rtl/elevator_pkg.sv */
////////////////////////////////////////////////////////////
// Elevator request unit types
// Floor numbers, request masks, dispatcher states and the
// packed bundles passed between the request unit blocks
////////////////////////////////////////////////////////////

package elevator_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // Bits in a floor number
    localparam int floor_width = 4;

    // Largest building the mask types can describe
    localparam int max_floors = 16;

    ////////////////////////////////////////////////////////////
    // Scalar types
    ////////////////////////////////////////////////////////////

    // Floor number, lowest floor is 0
    typedef logic [floor_width-1:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    typedef logic [max_floors-1:0] floor_mask_t;

    typedef enum logic {
        dir_down = 1'b0,
        dir_up   = 1'b1
    } direction_e;

    // Dispatcher FSM
    typedef enum logic [1:0] {
        idle   = 2'd0,
        offer  = 2'd1,
        travel = 2'd2
    } dispatch_state_e;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Buttons held down right now
    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t panel;
    } buttons_t;

    // Lit lamps, one per pending request
    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t panel;
    } lamps_t;

    // Position report from the car
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    // Command offered to the motion controller
    typedef struct packed {
        floor_t     target;
        direction_e direction;
    } move_cmd_t;

endpackage

/* rtl/request_register.sv */
////////////////////////////////////////////////////////////
// Request register
// Latches hall-call and car-panel presses into lamp bits and
// clears both lamps of the floor where the car stands
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module request_register #(
    parameter int num_floors = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::buttons_t    buttons,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      power_switch,
    input  logic                      emergency,
    output elevator_pkg::lamps_t      lamps
);

    import elevator_pkg::*;

    // Floors that exist in this building
    localparam floor_mask_t valid_mask = floor_mask_t'((32'd1 << num_floors) - 32'd1);

    if (num_floors < 2 || num_floors > max_floors) begin : g_num_floors_check
        $error("num_floors must lie between 2 and %0d", max_floors);
    end

    logic        in_service;
    logic        car_stopped;
    floor_mask_t car_mask;
    floor_mask_t hall_set;
    floor_mask_t panel_set;
    floor_mask_t clear_mask;
    lamps_t      lamps_next;

    assign in_service  = power_switch & ~emergency;
    assign car_stopped = ~car_status.moving;

    ////////////////////////////////////////////////////////////
    // Next lamp state
    ////////////////////////////////////////////////////////////

    always_comb begin
        // One-hot position of the car, empty if it reports a floor out of range
        car_mask = (floor_mask_t'(1) << car_status.floor) & valid_mask;

        // Presses at the car's own floor never light a lamp
        hall_set  = buttons.hall & valid_mask & ~car_mask;
        panel_set = buttons.panel & valid_mask & ~car_mask;

        // Arrival clears both lamps of the floor
        clear_mask = car_stopped ? car_mask : '0;

        // Out of service the lamps keep what they had
        lamps_next = lamps;
        if (in_service) begin
            lamps_next.hall  = (lamps.hall | hall_set) & ~clear_mask;
            lamps_next.panel = (lamps.panel | panel_set) & ~clear_mask;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lamp registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else begin
            lamps <= lamps_next;
        end
    end

    // Floors above the building never show a request
    a_lamps_in_range : assert property (
        @(posedge clock) disable iff (!reset_n)
        ((lamps.hall | lamps.panel) & ~valid_mask) == '0
    ) else $error("lamp lit above floor %0d", num_floors - 1);

endmodule

/* rtl/floor_dispatcher.sv */
////////////////////////////////////////////////////////////
// Floor dispatcher
// Picks the next target with a direction-keeping scan and
// offers it to the motion controller over valid/ready
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module floor_dispatcher #(
    parameter int num_floors = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::lamps_t      lamps,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      power_switch,
    input  logic                      emergency,
    output logic                      move_valid,
    output elevator_pkg::move_cmd_t   move_cmd,
    input  logic                      move_ready
);

    import elevator_pkg::*;

    localparam floor_mask_t valid_mask = floor_mask_t'((32'd1 << num_floors) - 32'd1);

    dispatch_state_e state;
    dispatch_state_e state_next;
    direction_e      dir_mem;
    move_cmd_t       cmd_next;

    logic        in_service;
    logic        car_stopped;
    logic        start_offer;
    logic        transfer;
    logic        arrived;
    floor_mask_t car_onehot;
    floor_mask_t below_all;
    floor_mask_t above_all;
    floor_mask_t pending;
    floor_mask_t pending_above;
    floor_mask_t pending_below;

    // Nearest floor above the car is the lowest set bit
    function automatic floor_t lowest_floor(input floor_mask_t mask);
        floor_t result;
        result = '0;
        for (int i = max_floors - 1; i >= 0; i--) begin
            if (mask[i]) begin
                result = floor_t'(i);
            end
        end
        return result;
    endfunction

    // Nearest floor below the car is the highest set bit
    function automatic floor_t highest_floor(input floor_mask_t mask);
        floor_t result;
        result = '0;
        for (int i = 0; i < max_floors; i++) begin
            if (mask[i]) begin
                result = floor_t'(i);
            end
        end
        return result;
    endfunction

    ////////////////////////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        car_onehot = floor_mask_t'(1) << car_status.floor;
        below_all  = car_onehot - floor_mask_t'(1);
        above_all  = ~(below_all | car_onehot);

        pending       = (lamps.hall | lamps.panel) & valid_mask & ~car_onehot;
        pending_above = pending & above_all;
        pending_below = pending & below_all;

        // Keep going up while there is work above, else prefer below
        if (dir_mem == dir_up && pending_above != '0) begin
            cmd_next.target = lowest_floor(pending_above);
        end else if (pending_below != '0) begin
            cmd_next.target = highest_floor(pending_below);
        end else begin
            cmd_next.target = lowest_floor(pending_above);
        end
        cmd_next.direction = (cmd_next.target > car_status.floor) ? dir_up : dir_down;
    end

    ////////////////////////////////////////////////////////////
    // Dispatcher FSM
    ////////////////////////////////////////////////////////////

    assign in_service  = power_switch & ~emergency;
    assign car_stopped = ~car_status.moving;
    assign start_offer = (state == idle) && in_service && car_stopped && (pending != '0);
    assign move_valid  = (state == offer);
    assign transfer    = move_valid && move_ready;
    assign arrived     = car_stopped && (car_status.floor == move_cmd.target);

    always_comb begin
        state_next = state;
        if (!in_service) begin
            state_next = idle;
        end else begin
            case (state)
                idle:    if (start_offer) state_next = offer;
                offer:   if (transfer) state_next = travel;
                travel:  if (arrived) state_next = idle;
                default: state_next = idle;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state   <= idle;
            dir_mem <= dir_up;
        end else begin
            state <= state_next;
            // Direction is remembered only once the car has taken the command
            if (state == offer && state_next == travel) begin
                dir_mem <= move_cmd.direction;
            end
        end
    end

    // Command is captured once per offer and then held
    always_ff @(posedge clock) begin
        if (start_offer) begin
            move_cmd <= cmd_next;
        end
    end

    a_cmd_stable : assert property (
        @(posedge clock) disable iff (!reset_n)
        move_valid && !move_ready && in_service |=> move_valid && $stable(move_cmd)
    ) else $error("move command changed under back-pressure");

    a_target_not_here : assert property (
        @(posedge clock) disable iff (!reset_n)
        start_offer |=> move_cmd.target != $past(car_status.floor)
    ) else $error("offered target equals the car floor");

endmodule

/* rtl/door_permit.sv */
////////////////////////////////////////////////////////////
// Door permit
// Registers door open and close requests, granted only
// while the car stands still with power on
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module door_permit (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      power_switch,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic permit_en;

    // Doors may only move with the car at rest
    assign permit_en = power_switch & ~car_status.moving;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= permit_en & door_open_button;
            door_close_allowed <= permit_en & door_close_button;
        end
    end

    // A moving car never leaves a door permit behind
    a_no_permit_in_motion : assert property (
        @(posedge clock) disable iff (!reset_n)
        car_status.moving |=> !door_open_allowed && !door_close_allowed
    ) else $error("door permit granted after car motion");

endmodule

/* rtl/elevator_request_unit.sv */
////////////////////////////////////////////////////////////
// Elevator request unit
// Lamp registers, target dispatcher and door permits for
// one elevator car
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module elevator_request_unit #(
    parameter int num_floors = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,

    // Buttons and car position
    input  elevator_pkg::buttons_t    buttons,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      power_switch,
    input  logic                      emergency,
    input  logic                      door_open_button,
    input  logic                      door_close_button,

    // Pending requests shown to passengers
    output elevator_pkg::lamps_t      lamps,

    // Move command to the motion controller
    output logic                      move_valid,
    output elevator_pkg::move_cmd_t   move_cmd,
    input  logic                      move_ready,

    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    request_register #(
        .num_floors (num_floors)
    ) request_register_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .buttons      (buttons),
        .car_status   (car_status),
        .power_switch (power_switch),
        .emergency    (emergency),
        .lamps        (lamps)
    );

    // Lamps double as the dispatcher's request list
    floor_dispatcher #(
        .num_floors (num_floors)
    ) floor_dispatcher_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .lamps        (lamps),
        .car_status   (car_status),
        .power_switch (power_switch),
        .emergency    (emergency),
        .move_valid   (move_valid),
        .move_cmd     (move_cmd),
        .move_ready   (move_ready)
    );

    door_permit door_permit_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .car_status         (car_status),
        .power_switch       (power_switch),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* tb/elevator_checker.sv */
////////////////////////////////////////////////////////////
// Elevator request unit checker
// Models lamps, door permits and the dispatcher scan, and
// compares them with the DUT outputs on every rising edge
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module elevator_checker #(
    parameter int num_floors = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::buttons_t    buttons,
    input  elevator_pkg::car_status_t car_status,
    input  logic                      power_switch,
    input  logic                      emergency,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      move_ready,
    input  elevator_pkg::lamps_t      lamps,
    input  logic                      move_valid,
    input  elevator_pkg::move_cmd_t   move_cmd,
    input  logic                      door_open_allowed,
    input  logic                      door_close_allowed,
    output int                        error_count
);

    import elevator_pkg::*;

    localparam floor_mask_t in_range = floor_mask_t'((32'd1 << num_floors) - 32'd1);

    lamps_t      lamp_model;
    direction_e  dir_model;
    move_cmd_t   cmd_expected;
    move_cmd_t   cmd_last;
    floor_t      trip_target;
    floor_mask_t car_bit;
    floor_mask_t car_free;
    floor_mask_t clear_bit;
    logic        service;
    logic        service_last;
    logic        valid_last;
    logic        ready_last;
    logic        trip_active;
    logic        arrived;
    logic        offer_allowed;
    logic        open_expected;
    logic        close_expected;

    task automatic flag_error(input string message);
        error_count++;
        $display("Error at %0t ns: %s", $time, message);
    endtask

    // Nearest request in the remembered direction before looking below and then above
    function automatic move_cmd_t expected_command(input lamps_t lit, input car_status_t car,
                                                   input direction_e dir);
        move_cmd_t   cmd;
        floor_mask_t pending;
        int          above;
        int          below;
        pending = lit.hall | lit.panel;
        above   = -1;
        below   = -1;
        for (int i = num_floors - 1; i > int'(car.floor); i--) begin
            if (pending[i]) above = i;
        end
        for (int i = 0; i < int'(car.floor); i++) begin
            if (pending[i]) below = i;
        end
        if (dir == dir_up && above >= 0) cmd.target = floor_t'(above);
        else if (below >= 0) cmd.target = floor_t'(below);
        else cmd.target = floor_t'(above);
        cmd.direction = (cmd.target > car.floor) ? dir_up : dir_down;
        return cmd;
    endfunction

    always @(posedge clock) begin
        if (!reset_n) begin
            lamp_model     = '0;
            dir_model      = dir_up;
            trip_active    = 1'b0;
            valid_last     = 1'b0;
            ready_last     = 1'b0;
            service_last   = 1'b1;
            offer_allowed  = 1'b0;
            open_expected  = 1'b0;
            close_expected = 1'b0;
        end else begin
            // Outputs seen here come from the previous edge
            if (lamps !== lamp_model) begin
                flag_error($sformatf("lamps %h, expected %h", lamps, lamp_model));
            end
            if ({door_open_allowed, door_close_allowed} !== {open_expected, close_expected}) begin
                flag_error($sformatf("door permits %b%b, expected %b%b", door_open_allowed,
                                     door_close_allowed, open_expected, close_expected));
            end
            if (move_valid && !valid_last && !offer_allowed) begin
                flag_error("move_valid rose with nothing to offer");
            end else if (move_valid && !valid_last && move_cmd !== cmd_expected) begin
                flag_error($sformatf("move_cmd %h, expected %h", move_cmd, cmd_expected));
            end
            if (offer_allowed && !move_valid) begin
                flag_error("move_valid stayed low with a request to offer");
            end
            if (valid_last && !ready_last && service_last &&
                (!move_valid || move_cmd !== cmd_last)) begin
                flag_error("offer changed or dropped under back-pressure");
            end
            if (move_valid && !service_last) begin
                flag_error("move_valid still high after loss of service");
            end

            ////////////////////////////////////////////////////////////
            // Sample this edge and advance the model
            ////////////////////////////////////////////////////////////
            service  = power_switch && !emergency;
            car_bit  = in_range & (floor_mask_t'(1) << car_status.floor);
            car_free = in_range & ~car_bit;
            offer_allowed = service && !car_status.moving && !trip_active && !move_valid &&
                            (((lamp_model.hall | lamp_model.panel) & ~car_bit) != '0);
            cmd_expected  = expected_command(lamp_model, car_status, dir_model);

            // Trip ends at the target or on loss of service
            arrived = !car_status.moving && car_status.floor == trip_target;
            if (trip_active && (!service || arrived)) begin
                trip_active = 1'b0;
            end
            if (move_valid && move_ready && service) begin
                if (trip_active) begin
                    flag_error("second transfer before the car reached its target");
                end
                trip_active = 1'b1;
                trip_target = move_cmd.target;
                dir_model   = move_cmd.direction;
            end

            if (service) begin
                clear_bit        = car_status.moving ? '0 : car_bit;
                lamp_model.hall  = (lamp_model.hall | (buttons.hall & car_free)) & ~clear_bit;
                lamp_model.panel = (lamp_model.panel | (buttons.panel & car_free)) & ~clear_bit;
            end
            open_expected  = power_switch && !car_status.moving && door_open_button;
            close_expected = power_switch && !car_status.moving && door_close_button;
            service_last   = service;
            valid_last     = move_valid;
            ready_last     = move_ready;
            cmd_last       = move_cmd;
        end
    end

endmodule

/* tb/elevator_request_unit_tb.sv */
////////////////////////////////////////////////////////////
// Elevator request unit testbench
// LFSR button presses, ready stalls and outages, with a
// simple car model that serves the move commands
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module elevator_request_unit_tb;

    import elevator_pkg::*;

    localparam int num_floors    = 11;
    localparam int rounds        = 40;
    localparam int drain_timeout = 3000;

    logic        clock;
    logic        reset_n;
    buttons_t    buttons;
    car_status_t car_status;
    logic        power_switch;
    logic        emergency;
    logic        door_open_button;
    logic        door_close_button;
    logic        move_ready;
    logic        move_valid;
    move_cmd_t   move_cmd;
    lamps_t      lamps;
    logic        door_open_allowed;
    logic        door_close_allowed;
    int          error_count;

    // Stimulus and car model state
    logic [15:0] lfsr_state;
    floor_t      car_target;
    logic        move_taken;
    int          step_timer;
    int          outage;
    logic        outage_kind;
    logic        timed_out;

    elevator_request_unit #(.num_floors(num_floors)) dut_i (.*);

    elevator_checker #(.num_floors(num_floors)) checker_i (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit taken
    function automatic logic [7:0] lfsr_bits(input int count);
        logic [7:0] value;
        logic       feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value      = {value[6:0], feedback};
        end
        return value;
    endfunction

    // One cycle of stimulus on the falling edge
    task automatic drive_cycle(input logic allow_press);
        floor_t press_floor;
        @(negedge clock);
        // Car steps one floor every third cycle
        if (car_status.moving) begin
            step_timer++;
            if (step_timer == 3) begin
                step_timer = 0;
                if (car_target > car_status.floor) car_status.floor = car_status.floor + 1'b1;
                else car_status.floor = car_status.floor - 1'b1;
                car_status.moving = (car_status.floor != car_target);
            end
        end else if (move_taken) begin
            car_status.moving = 1'b1;
            step_timer        = 0;
        end
        // Emergency or power-off windows start only with the car at rest
        if (outage > 0) begin
            outage--;
        end else if (allow_press && !car_status.moving && lfsr_bits(4) == 0) begin
            outage      = 2 + lfsr_bits(2);
            outage_kind = (lfsr_bits(1) != 0);
        end
        emergency    = (outage > 0) && outage_kind;
        power_switch = !((outage > 0) && !outage_kind);
        // At most one button per cycle over all 16 floor bits
        buttons = '0;
        if (allow_press && lfsr_bits(2) == 0) begin
            press_floor = floor_t'(lfsr_bits(4));
            if (lfsr_bits(1)) buttons.hall[press_floor] = 1'b1;
            else buttons.panel[press_floor] = 1'b1;
        end
        door_open_button  = (lfsr_bits(1) != 0);
        door_close_button = (lfsr_bits(1) != 0);
        // Ready stalls about a quarter of the time
        move_ready = (outage == 0) && (lfsr_bits(2) != 0);
        move_taken = move_valid && move_ready;
        if (move_taken) car_target = move_cmd.target;
    endtask

    initial begin : stimulus
        int waited;
        lfsr_state        = 16'd31;
        reset_n           = 1'b0;
        buttons           = '0;
        car_status        = '0;
        power_switch      = 1'b1;
        emergency         = 1'b0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        move_ready        = 1'b0;
        move_taken        = 1'b0;
        car_target        = '0;
        step_timer        = 0;
        outage            = 0;
        outage_kind       = 1'b0;
        timed_out         = 1'b0;
        repeat (8) @(negedge clock);
        reset_n = 1'b1;

        for (int round = 0; round < rounds && !timed_out; round++) begin
            repeat (20) drive_cycle(1'b1);
            // No new presses until every lamp is served
            waited = 0;
            while (!timed_out && ((lamps.hall | lamps.panel) != '0 || move_valid ||
                                  car_status.moving || outage > 0)) begin
                drive_cycle(1'b0);
                waited++;
                timed_out = (waited >= drain_timeout);
            end
        end

        if (timed_out) begin
            $display("Timeout: requests still pending after %0d cycles", drain_timeout);
        end
        $display("Closing count: %0d errors, %0d timeouts", error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* elevator_request_unit.f */
rtl/elevator_pkg.sv
rtl/request_register.sv
rtl/floor_dispatcher.sv
rtl/door_permit.sv
rtl/elevator_request_unit.sv
tb/elevator_checker.sv
tb/elevator_request_unit_tb.sv

/* Bender.yml */
package:
  name: elevator_request_unit

sources:
  - rtl/elevator_pkg.sv
  - rtl/request_register.sv
  - rtl/floor_dispatcher.sv
  - rtl/door_permit.sv
  - rtl/elevator_request_unit.sv
  - target: test
    files:
      - tb/elevator_checker.sv
      - tb/elevator_request_unit_tb.sv
